//--- testbench/intRegRead_tests.txt
# Commands: test name, preload reg value, op (stages one lane), issue, stall n, flush head tail
# op columns (hex): lane valid alu(0 add 1 sub 2 and 3 or 4 xor) typeA typeB srcA srcB dst wr immType imm pc tag
test reset
op 0 1 0 0 0 3 4 0 0 0 0 0 1
op 1 1 0 0 0 7 1f 0 0 0 0 0 2
issue
endtest
test alu
preload 1 00123
preload 2 00456
preload 3 fff00
op 0 1 1 0 0 2 1 0 0 0 0 0 3
op 1 1 4 0 0 3 2 0 0 0 0 0 4
issue
op 0 1 2 0 0 3 2 0 0 0 0 0 5
op 1 1 3 0 0 1 2 0 0 0 0 0 6
issue
op 0 1 0 0 0 1 3 0 0 0 0 0 7
issue
endtest
test immpc
op 0 1 0 0 1 1 0 0 0 0 80001 0 8
op 1 1 0 2 1 0 0 0 0 1 abcde 1000 9
issue
endtest
test writeback
op 0 1 0 0 0 1 2 5 1 0 0 0 a
op 1 1 0 0 1 0 0 0 1 0 00077 0 b
issue
op 0 1 1 0 0 5 1 0 0 0 0 0 c
op 1 1 0 0 0 0 5 0 0 0 0 0 d
issue
op 0 1 0 0 1 0 0 6 1 0 00011 0 e
op 1 1 0 0 1 0 0 6 1 0 00022 0 f
issue
op 0 1 0 0 0 6 0 0 0 0 0 0 10
issue
endtest
test stall
op 0 1 0 0 1 1 0 0 0 0 00010 0 11
op 1 1 1 0 0 2 1 0 0 0 0 0 12
issue
# Offered while stalled, so these two are dropped
op 0 1 4 0 0 1 2 0 0 0 0 0 13
op 1 1 4 0 0 2 3 0 0 0 0 0 14
stall 3
endtest
test flush
op 0 1 0 0 0 1 2 0 0 0 0 0 12
op 1 1 0 0 0 2 3 0 0 0 0 0 18
issue
flush 10 15
op 0 1 0 0 0 1 1 0 0 0 0 0 1e
op 1 1 0 0 0 3 3 0 0 0 0 0 2
issue
flush 1c 3
op 0 1 0 0 0 1 2 0 0 0 0 0 7
op 1 1 0 0 0 2 3 0 0 0 0 0 9
issue
flush 4 4
endtest

//--- list.f
+incdir+design
design/intRrPkg.sv
design/physRegFile.sv
design/operandSelectLane.sv
design/intExecWriteback.sv
design/intRegReadTop.sv
testbench/intRegRead_assert.sv
testbench/intRegReadTb.sv

//--- run.sh
#!/bin/sh
# Build and run the back end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module intRegReadTb -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulator returned an error"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0

//--- testbench/intRegReadTb.sv
//**************************************************
// Testbench for the integer register read back end.
// Reads commands from the tests data file, keeps a
// register model and checks every lane result
//**************************************************
`timescale 1ns/1ps
`default_nettype none

`include "intRr_macros.svh"

module intRegReadTb;
    import intRrPkg::*;

    logic      clk = 1'b0;
    logic      rstN;
    logic      stall;
    FlushRange flushIn;
    IssuedOp   issue  [`INT_ISSUE_WIDTH];
    ExecResult result [`INT_ISSUE_WIDTH];
    IssuedOp   staged [`INT_ISSUE_WIDTH];
    IssuedOp   held   [`INT_ISSUE_WIDTH];
    DataPath   modelRegs [`PREG_NUM];
    ExecResult expQ [`INT_ISSUE_WIDTH][$];
    // Edge at which each expected result is due
    int        dueQ [`INT_ISSUE_WIDTH][$];
    int        edgeCount = 0;
    int        fd;
    int        checks = 0;
    int        errors = 0;
    int        testChecks = 0;
    int        testErrors = 0;
    int        testsRun = 0;
    string     cmd;
    string     testName;

    always #5 clk = ~clk;

    always @(posedge clk) begin
        edgeCount++;
    end

    intRegReadTop i_intRegReadTop (
        .clk     (clk),
        .rstN    (rstN),
        .stall   (stall),
        .flushIn (flushIn),
        .issue   (issue),
        .result  (result)
    );

    // Circular range, head inclusive and tail exclusive
    function automatic logic inFlush(FlushRange fr, ActiveListPtr tag);
        if (!fr.flush) begin
            return 1'b0;
        end
        if (fr.headPtr == fr.tailPtr) begin
            return 1'b1;
        end
        if (fr.headPtr < fr.tailPtr) begin
            return (tag >= fr.headPtr) && (tag < fr.tailPtr);
        end
        return (tag >= fr.headPtr) || (tag < fr.tailPtr);
    endfunction

    function automatic DataPath operandValue(IssuedOp op, OperandType t, PRegNum src);
        DataPath immV;
        if (op.immType == IMM_U) begin
            immV = {op.imm, 12'h000};
        end else begin
            immV = {{12{op.imm[19]}}, op.imm};
        end
        if (t == OT_IMM) begin
            return immV;
        end
        if (t == OT_PC) begin
            return op.pc;
        end
        return modelRegs[src];
    endfunction

    function automatic DataPath aluRef(IntAluCode code, DataPath a, DataPath b);
        case (code)
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            default: return a + b;
        endcase
    endfunction

    // Model one cycle with the inputs already driven, then pass the edge
    task automatic stepCycle();
        ExecResult exp;
        logic      wrEn [`INT_ISSUE_WIDTH];
        for (int i = 0; i < `INT_ISSUE_WIDTH; i++) begin
            wrEn[i] = 1'b0;
            if (held[i].valid && !stall && !inFlush(flushIn, held[i].tag)) begin
                exp.valid    = 1'b1;
                exp.tag      = held[i].tag;
                exp.dst      = held[i].dst;
                exp.writeReg = held[i].writeReg;
                exp.data     = aluRef(held[i].aluCode,
                    operandValue(held[i], held[i].operandTypeA, held[i].srcA),
                    operandValue(held[i], held[i].operandTypeB, held[i].srcB));
                expQ[i].push_back(exp);
                dueQ[i].push_back(edgeCount + 1);
                wrEn[i] = held[i].writeReg && (held[i].dst != '0);
            end
        end
        // Lane order, so lane 1 wins a shared destination
        for (int i = 0; i < `INT_ISSUE_WIDTH; i++) begin
            if (wrEn[i]) begin
                modelRegs[held[i].dst] = expQ[i][expQ[i].size()-1].data;
            end
        end
        for (int i = 0; i < `INT_ISSUE_WIDTH; i++) begin
            if (!stall) begin
                held[i] = issue[i];
            end else if (inFlush(flushIn, held[i].tag)) begin
                held[i].valid = 1'b0;
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic clearIssue();
        for (int i = 0; i < `INT_ISSUE_WIDTH; i++) begin
            issue[i]  = '0;
            staged[i] = '0;
        end
    endtask

    task automatic readOp();
        int lane, v, alu, ta, tb, sa, sb, dst, wr, it, imm, pc, tag, n;
        n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h", lane, v, alu, ta, tb,
                    sa, sb, dst, wr, it, imm, pc, tag);
        staged[lane[0]].valid        = v[0];
        staged[lane[0]].aluCode      = IntAluCode'(alu[2:0]);
        staged[lane[0]].operandTypeA = OperandType'(ta[1:0]);
        staged[lane[0]].operandTypeB = OperandType'(tb[1:0]);
        staged[lane[0]].srcA         = sa[4:0];
        staged[lane[0]].srcB         = sb[4:0];
        staged[lane[0]].dst          = dst[4:0];
        staged[lane[0]].writeReg     = wr[0];
        staged[lane[0]].immType      = ImmType'(it[0]);
        staged[lane[0]].imm          = imm[19:0];
        staged[lane[0]].pc           = pc;
        staged[lane[0]].tag          = tag[4:0];
    endtask

    task automatic skipLine();
        int c;
        c = $fgetc(fd);
        while (c != 10 && c != -1) begin
            c = $fgetc(fd);
        end
    endtask

    // At least two cycles, then up to 20 for pending results
    task automatic drainAndReport();
        int w;
        w = 0;
        while (w < 20 && (w < 2 || expQ[0].size() != 0 || expQ[1].size() != 0)) begin
            stepCycle();
            w++;
        end
        if (expQ[0].size() != 0 || expQ[1].size() != 0) begin
            $display("Timeout: expected results did not arrive within 20 cycles in %s",
                     testName);
            errors++;
            testErrors++;
            expQ[0].delete();
            expQ[1].delete();
            dueQ[0].delete();
            dueQ[1].delete();
        end
        $display("Test %s: %0d checks, %0d errors", testName, testChecks, testErrors);
        testsRun++;
    endtask

    always @(negedge clk) begin : monitor
        ExecResult exp;
        int        due;
        for (int i = 0; i < `INT_ISSUE_WIDTH; i++) begin
            if (rstN && result[i].valid) begin
                checks++;
                testChecks++;
                assert (expQ[i].size() != 0)
                else begin
                    $display("Lane %0d gave a result that was not expected at time %0t",
                             i, $time);
                    errors++;
                    testErrors++;
                end
                if (expQ[i].size() != 0) begin
                    exp = expQ[i].pop_front();
                    due = dueQ[i].pop_front();
                    assert (result[i].data == exp.data && result[i].dst == exp.dst &&
                            result[i].tag == exp.tag &&
                            result[i].writeReg == exp.writeReg)
                    else begin
                        $display("FAILED at %0t: lane %0d tag %0h data %h dst %0d wr %0b",
                                 $time, i, result[i].tag, result[i].data, result[i].dst,
                                 result[i].writeReg);
                        $display("Lane %0d expected tag %0h data %h dst %0d wr %0b",
                                 i, exp.tag, exp.data, exp.dst, exp.writeReg);
                        errors++;
                        testErrors++;
                    end
                    assert (due == edgeCount)
                    else begin
                        $display("Lane %0d result came at edge %0d instead of edge %0d",
                                 i, edgeCount, due);
                        errors++;
                        testErrors++;
                    end
                end
            end
        end
    end

    initial begin
        int h;
        int t;
        int r;
        int v;
        int n;
        rstN    = 1'b0;
        stall   = 1'b0;
        flushIn = '0;
        clearIssue();
        for (int i = 0; i < `INT_ISSUE_WIDTH; i++) begin
            held[i] = '0;
        end
        for (int i = 0; i < `PREG_NUM; i++) begin
            modelRegs[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rstN = 1'b1;
        assert (!result[0].valid && !result[1].valid)
        else begin
            $display("FAILED at %0t: result valid right after reset", $time);
            errors++;
        end
        fd = $fopen("testbench/intRegRead_tests.txt", "r");
        if (fd == 0) begin
            $display("The test data file could not be opened");
            $display("Simulation failed");
            $finish;
        end else begin
            while ($fscanf(fd, "%s", cmd) == 1) begin
                if (cmd.getc(0) == 8'h23) begin
                    skipLine();
                end else if (cmd == "test") begin
                    n = $fscanf(fd, "%s", testName);
                    testChecks = 0;
                    testErrors = 0;
                end else if (cmd == "op") begin
                    readOp();
                end else if (cmd == "preload") begin
                    n = $fscanf(fd, "%h %h", r, v);
                    staged[0] = '0;
                    staged[0].valid        = 1'b1;
                    staged[0].aluCode      = ADD;
                    staged[0].operandTypeB = OT_IMM;
                    staged[0].imm          = v[19:0];
                    staged[0].dst          = r[4:0];
                    staged[0].writeReg     = 1'b1;
                    issue = staged;
                    stepCycle();
                    clearIssue();
                end else if (cmd == "issue") begin
                    issue = staged;
                    stepCycle();
                    clearIssue();
                end else if (cmd == "stall") begin
                    n = $fscanf(fd, "%d", r);
                    stall = 1'b1;
                    issue = staged;
                    repeat (r) stepCycle();
                    stall = 1'b0;
                    clearIssue();
                end else if (cmd == "flush") begin
                    n = $fscanf(fd, "%h %h", h, t);
                    flushIn.flush   = 1'b1;
                    flushIn.headPtr = h[4:0];
                    flushIn.tailPtr = t[4:0];
                    stepCycle();
                    flushIn = '0;
                end else if (cmd == "idle") begin
                    stepCycle();
                end else if (cmd == "endtest") begin
                    drainAndReport();
                end
            end
            $fclose(fd);
            $display("Tests: %0d, checks: %0d, errors: %0d", testsRun, checks, errors);
            if (errors == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

    initial begin
        #200000;
        $display("Timeout: the run did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/intRegRead_assert.sv
//**************************************************
// Concurrent checks on the back end top level,
// attached by bind to every instance of the top
//**************************************************
`timescale 1ns/1ps
`default_nettype none

`include "intRr_macros.svh"

module intRegReadAssert (
    input logic                clk,
    input logic                rstN,
    input logic                stall,
    input intRrPkg::RegWrite   regWrite [`INT_ISSUE_WIDTH],
    input intRrPkg::ExecResult result   [`INT_ISSUE_WIDTH]
);
    for (genvar i = 0; i < `INT_ISSUE_WIDTH; i++) begin : gChk
        // A stall cycle sends a bubble
        assert property (@(posedge clk) disable iff (!rstN) stall |=> !result[i].valid)
        else $error("Result valid after a stall cycle on lane %0d", i);

        assert property (@(posedge clk) !rstN |-> !regWrite[i].en)
        else $error("Write enable high during reset on lane %0d", i);

        // Write and result capture share an edge
        assert property (@(posedge clk) disable iff (!rstN) regWrite[i].en |=> result[i].valid)
        else $error("Write without a valid result on lane %0d", i);
    end

endmodule

bind intRegReadTop intRegReadAssert i_intRegReadAssert (
    .clk      (clk),
    .rstN     (rstN),
    .stall    (stall),
    .regWrite (regWrite),
    .result   (result)
);

`default_nettype wire

//--- design/intRegReadTop.sv
//**************************************************
// Integer back end top: register file, one register
// read lane per issue slot and the shared execute
// and writeback unit
//**************************************************
`timescale 1ns/1ps
`default_nettype none

`include "intRr_macros.svh"

module intRegReadTop (
    input  logic                clk,
    input  logic                rstN,
    input  logic                stall,
    input  intRrPkg::FlushRange flushIn,
    input  intRrPkg::IssuedOp   issue  [`INT_ISSUE_WIDTH],
    output intRrPkg::ExecResult result [`INT_ISSUE_WIDTH]
);
    import intRrPkg::*;

    PRegNum      rdAddrA  [`INT_ISSUE_WIDTH];
    PRegNum      rdAddrB  [`INT_ISSUE_WIDTH];
    DataPath     rdDataA  [`INT_ISSUE_WIDTH];
    DataPath     rdDataB  [`INT_ISSUE_WIDTH];
    ReadOperands readOut  [`INT_ISSUE_WIDTH];
    RegWrite     regWrite [`INT_ISSUE_WIDTH];

    physRegFile i_physRegFile (
        .clk      (clk),
        .rstN     (rstN),
        .rdAddrA  (rdAddrA),
        .rdAddrB  (rdAddrB),
        .rdDataA  (rdDataA),
        .rdDataB  (rdDataB),
        .regWrite (regWrite)
    );

    for (genvar i = 0; i < `INT_ISSUE_WIDTH; i++) begin : gLane
        operandSelectLane i_operandSelectLane (
            .clk     (clk),
            .rstN    (rstN),
            .stall   (stall),
            .flushIn (flushIn),
            .issueOp (issue[i]),
            .rdAddrA (rdAddrA[i]),
            .rdAddrB (rdAddrB[i]),
            .rdDataA (rdDataA[i]),
            .rdDataB (rdDataB[i]),
            .readOut (readOut[i])
        );
    end

    intExecWriteback i_intExecWriteback (
        .clk      (clk),
        .rstN     (rstN),
        .readOut  (readOut),
        .regWrite (regWrite),
        .result   (result)
    );

endmodule

`default_nettype wire

//--- design/intExecWriteback.sv
//**************************************************
// Execute and writeback for all lanes. Runs the ALU
// on the read operands, registers the results and
// writes the register file at the same clock edge
//**************************************************
`timescale 1ns/1ps
`default_nettype none

`include "intRr_macros.svh"

module intExecWriteback (
    input  logic                  clk,
    input  logic                  rstN,
    input  intRrPkg::ReadOperands readOut  [`INT_ISSUE_WIDTH],
    output intRrPkg::RegWrite     regWrite [`INT_ISSUE_WIDTH],
    output intRrPkg::ExecResult   result   [`INT_ISSUE_WIDTH]
);
    import intRrPkg::*;

    DataPath aluOut [`INT_ISSUE_WIDTH];

    // Arithmetic wraps at the data width
    function automatic DataPath aluCompute(IntAluCode code, DataPath a, DataPath b);
        DataPath value;
        case (code)
            ADD:     value = a + b;
            SUB:     value = a - b;
            AND:     value = a & b;
            OR:      value = a | b;
            XOR:     value = a ^ b;
            default: value = '0;
        endcase
        return value;
    endfunction

    always_comb begin
        for (int i = 0; i < `INT_ISSUE_WIDTH; i++) begin
            aluOut[i] = aluCompute(readOut[i].aluCode, readOut[i].operandA,
                                   readOut[i].operandB);

            // Write lands on the same edge that captures the result
            regWrite[i].en   = readOut[i].valid && readOut[i].writeReg;
            regWrite[i].addr = readOut[i].dst;
            regWrite[i].data = aluOut[i];
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `INT_ISSUE_WIDTH; i++) begin
            if (!rstN) begin
                result[i].valid <= 1'b0;
            end else begin
                result[i].valid <= readOut[i].valid;
            end
            result[i].tag      <= readOut[i].tag;
            result[i].dst      <= readOut[i].dst;
            result[i].writeReg <= readOut[i].writeReg;
            result[i].data     <= aluOut[i];
        end
    end

endmodule

`default_nettype wire

//--- design/operandSelectLane.sv
//**************************************************
// One integer issue lane: pipeline register, source
// reads, immediate decode, operand selection and
// selective flush. Instantiated once per lane
//**************************************************
`timescale 1ns/1ps
`default_nettype none

`include "intRr_macros.svh"

module operandSelectLane (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  stall,
    input  intRrPkg::FlushRange   flushIn,
    input  intRrPkg::IssuedOp     issueOp,
    output intRrPkg::PRegNum      rdAddrA,
    output intRrPkg::PRegNum      rdAddrB,
    input  intRrPkg::DataPath     rdDataA,
    input  intRrPkg::DataPath     rdDataB,
    output intRrPkg::ReadOperands readOut
);
    import intRrPkg::*;

    IssuedOp pipeReg;
    DataPath immOut;
    logic    flushHit;

    function automatic DataPath decodeImm(ImmType immType, ImmField imm);
        DataPath value;
        if (immType == IMM_U) begin
            value = {imm.immU, {(`DATA_WIDTH-`IMM_WIDTH){1'b0}}};
        end else begin
            value = {{(`DATA_WIDTH-`IMM_WIDTH){imm.immI[`IMM_WIDTH-1]}}, imm.immI};
        end
        return value;
    endfunction

    function automatic DataPath selectOperand(OperandType opType, DataPath regV,
                                              DataPath immV, DataPath pcV);
        case (opType)
            OT_IMM:  return immV;
            OT_PC:   return pcV;
            default: return regV;
        endcase
    endfunction

    // Circular range, head == tail means the whole ring
    function automatic logic tagInRange(FlushRange fr, ActiveListPtr tag);
        logic hit;
        if (fr.headPtr == fr.tailPtr) begin
            hit = 1'b1;
        end else if (fr.headPtr < fr.tailPtr) begin
            hit = (tag >= fr.headPtr) && (tag < fr.tailPtr);
        end else begin
            hit = (tag >= fr.headPtr) || (tag < fr.tailPtr);
        end
        return fr.flush && hit;
    endfunction

    // Flush under stall drops the held op; otherwise it is replaced anyway
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pipeReg.valid <= 1'b0;
        end else if (!stall) begin
            pipeReg <= issueOp;
        end else if (flushHit) begin
            pipeReg.valid <= 1'b0;
        end
    end

    always_comb begin
        rdAddrA  = pipeReg.srcA;
        rdAddrB  = pipeReg.srcB;
        flushHit = tagInRange(flushIn, pipeReg.tag);
        immOut   = decodeImm(pipeReg.immType, pipeReg.imm);

        readOut.valid    = pipeReg.valid && !stall && !flushHit;
        readOut.aluCode  = pipeReg.aluCode;
        readOut.operandA = selectOperand(pipeReg.operandTypeA, rdDataA, immOut, pipeReg.pc);
        readOut.operandB = selectOperand(pipeReg.operandTypeB, rdDataB, immOut, pipeReg.pc);
        readOut.dst      = pipeReg.dst;
        readOut.writeReg = pipeReg.writeReg;
        readOut.tag      = pipeReg.tag;
    end

endmodule

`default_nettype wire

//--- design/physRegFile.sv
//**************************************************
// Physical register file shared by all issue lanes.
// Two asynchronous read ports and one write port per
// lane; register 0 is hardwired to zero
//**************************************************
`timescale 1ns/1ps
`default_nettype none

`include "intRr_macros.svh"

module physRegFile (
    input  logic              clk,
    input  logic              rstN,
    input  intRrPkg::PRegNum  rdAddrA  [`INT_ISSUE_WIDTH],
    input  intRrPkg::PRegNum  rdAddrB  [`INT_ISSUE_WIDTH],
    output intRrPkg::DataPath rdDataA  [`INT_ISSUE_WIDTH],
    output intRrPkg::DataPath rdDataB  [`INT_ISSUE_WIDTH],
    input  intRrPkg::RegWrite regWrite [`INT_ISSUE_WIDTH]
);
    import intRrPkg::*;

    DataPath regs [`PREG_NUM];

    // Later lanes overwrite earlier ones, so the highest lane wins a conflict
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int r = 0; r < `PREG_NUM; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int i = 0; i < `INT_ISSUE_WIDTH; i++) begin
                if (regWrite[i].en && (regWrite[i].addr != '0)) begin
                    regs[regWrite[i].addr] <= regWrite[i].data;
                end
            end
        end
    end

    // Asynchronous reads
    always_comb begin
        for (int i = 0; i < `INT_ISSUE_WIDTH; i++) begin
            if (rdAddrA[i] == '0) begin
                rdDataA[i] = '0;
            end else begin
                rdDataA[i] = regs[rdAddrA[i]];
            end

            if (rdAddrB[i] == '0) begin
                rdDataB[i] = '0;
            end else begin
                rdDataB[i] = regs[rdAddrB[i]];
            end
        end
    end

endmodule

`default_nettype wire

//--- design/intRrPkg.sv
//**************************************************
// Shared types for the integer register read path:
// issued micro-ops, lane outputs, flush ranges,
// register writes and execute results
//**************************************************
`default_nettype none

`include "intRr_macros.svh"

package intRrPkg;

    typedef logic [`DATA_WIDTH-1:0] DataPath;
    typedef logic [`PREG_BITS-1:0]  PRegNum;
    typedef logic [`TAG_WIDTH-1:0]  ActiveListPtr;

    typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR} IntAluCode;

    typedef enum logic [1:0] {OT_REG, OT_IMM, OT_PC} OperandType;

    typedef enum logic {IMM_I, IMM_U} ImmType;

    // Same 20 bits, read as a signed I field or as the upper U field
    typedef union packed {
        logic signed [`IMM_WIDTH-1:0] immI;
        logic        [`IMM_WIDTH-1:0] immU;
    } ImmField;

    typedef struct packed {
        logic         valid;
        IntAluCode    aluCode;
        OperandType   operandTypeA;
        OperandType   operandTypeB;
        PRegNum       srcA;
        PRegNum       srcB;
        PRegNum       dst;
        logic         writeReg;
        ImmType       immType;
        ImmField      imm;
        DataPath      pc;
        ActiveListPtr tag;
    } IssuedOp;

    typedef struct packed {
        logic         valid;
        IntAluCode    aluCode;
        DataPath      operandA;
        DataPath      operandB;
        PRegNum       dst;
        logic         writeReg;
        ActiveListPtr tag;
    } ReadOperands;

    // Head inclusive, tail exclusive
    typedef struct packed {
        logic         flush;
        ActiveListPtr headPtr;
        ActiveListPtr tailPtr;
    } FlushRange;

    typedef struct packed {
        logic    en;
        PRegNum  addr;
        DataPath data;
    } RegWrite;

    typedef struct packed {
        logic         valid;
        ActiveListPtr tag;
        PRegNum       dst;
        logic         writeReg;
        DataPath      data;
    } ExecResult;

endpackage

`default_nettype wire

//--- design/intRr_macros.svh
//**************************************************
// Width and count macros for the integer register
// read back end. Included by the package, the RTL
// modules and the testbench wherever sizes are needed
//**************************************************
`ifndef INTRR_MACROS_SVH
`define INTRR_MACROS_SVH

// Number of integer issue lanes
`define INT_ISSUE_WIDTH 2

`define DATA_WIDTH 32
`define PREG_NUM 32
`define PREG_BITS 5
// Active list pointer width
`define TAG_WIDTH 5
`define IMM_WIDTH 20

`endif
